//--- Makefile
TOP = lsuTb

all: run

run:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f lsuSubsystem.f -o lsuSim
	@out=$$(./obj_dir/lsuSim +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

lint:
	verilator --lint-only --timing --top-module lsuTop -f lsuSubsystem.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

//--- common/lsuPkg.sv
`default_nettype none

package lsuPkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  byteEn_t;
    typedef logic [31:0] instTag_t;

    // Encodings follow RISC-V funct3
    typedef enum logic [2:0] {
        opByte  = 3'd0,
        opHalf  = 3'd1,
        opWord  = 3'd2,
        opByteU = 3'd4,
        opHalfU = 3'd5
    } memOp_e;

    typedef struct packed {
        logic     isStore;
        memOp_e   op;
        word_t    addr;      // Byte address
        word_t    storeData; // Right-aligned store value
        instTag_t tag;
    } lsuReq_t;

    typedef struct packed {
        instTag_t tag;       // Echo of the request tag
        word_t    loadData;  // Zero for stores and faults
        logic     fault;
    } lsuResp_t;

    // Added to each word index by the reset sweep
    localparam int unsigned InitOffset = 3;

endpackage

`default_nettype wire

//--- common/memBusIf.sv
`timescale 1ns/1ps
`default_nettype none

interface memBusIf #(
    parameter int AddrBits = 11
);
    import lsuPkg::*;

    logic                req;
    logic                we;
    logic [AddrBits-1:0] wordAddr;
    word_t               wdata;
    byteEn_t             byteEn;
    logic                gnt;
    logic                rvalid;   // One cycle after a read grant
    word_t               rdata;

    modport requester (
        output req, we, wordAddr, wdata, byteEn,
        input  gnt, rvalid, rdata
    );

    modport arbiter (
        input  req, we, wordAddr, wdata, byteEn,
        output gnt, rvalid, rdata
    );

    modport memory (
        input  req, we, wordAddr, wdata, byteEn,
        output gnt, rvalid, rdata
    );

endinterface

`default_nettype wire

//--- dataMemory/dataMemory.sv
`timescale 1ns/1ps
`default_nettype none

module dataMemory #(
    parameter int MemWords = 2048
) (
    input  logic    clk,
    input  logic    reset,
    memBusIf.memory bus
);
    import lsuPkg::*;

    localparam int AddrBits = $clog2(MemWords);

    word_t               mem [MemWords];
    logic [AddrBits-1:0] sweepIdx;
    logic                sweeping;    // Init sweep in progress

    always_ff @(posedge clk) begin
        if (reset) begin
            sweeping <= 1'b1;
            sweepIdx <= '0;
        end else if (sweeping) begin
            sweepIdx <= sweepIdx + 1'b1;
            if (sweepIdx == '1) begin
                sweeping <= 1'b0;
            end
        end
    end

    assign bus.gnt = ~sweeping;       // No accesses during the sweep

    always_ff @(posedge clk) begin
        if (sweeping) begin
            mem[sweepIdx] <= word_t'(sweepIdx) + word_t'(InitOffset);
        end else if (bus.req && bus.we) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.byteEn[b]) begin
                    mem[bus.wordAddr][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.rvalid <= 1'b0;
        end else begin
            bus.rvalid <= bus.req && !bus.we && bus.gnt;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.req && !bus.we && bus.gnt) begin
            bus.rdata <= mem[bus.wordAddr];
        end
    end

endmodule

`default_nettype wire

//--- dv/lsuChecker.sv
`timescale 1ns/1ps
`default_nettype none

module lsuChecker (
    input logic clk,
    input logic reset,
    input logic bValid,
    input logic bReady,
    input logic rValid,
    input logic rReady,
    input logic lsuReq,
    input logic lsuGnt,
    input logic hostReq,
    input logic hostGnt
);
    int fails = 0;    // Summed into the testbench error count

    bHeld: assert property (@(posedge clk) disable iff (reset) bValid && !bReady |=> bValid)
        else begin
            $error("bValid dropped before bReady");
            fails++;
        end

    rHeld: assert property (@(posedge clk) disable iff (reset) rValid && !rReady |=> rValid)
        else begin
            $error("rValid dropped before rReady");
            fails++;
        end

    oneGrant: assert property (@(posedge clk) disable iff (reset) !(lsuGnt && hostGnt))
        else begin
            $error("both requesters granted in one cycle");
            fails++;
        end

    lsuGntReq: assert property (@(posedge clk) disable iff (reset) lsuGnt |-> lsuReq)
        else begin
            $error("LSU granted without a request");
            fails++;
        end

    hostGntReq: assert property (@(posedge clk) disable iff (reset) hostGnt |-> hostReq)
        else begin
            $error("host granted without a request");
            fails++;
        end

endmodule

bind axiLiteSlave lsuChecker axiChk0 (
    .clk, .reset, .bValid, .bReady, .rValid, .rReady,
    .lsuReq(1'b0), .lsuGnt(1'b0), .hostReq(1'b0), .hostGnt(1'b0)
);

bind memArbiter lsuChecker arbChk0 (
    .clk, .reset, .bValid(1'b0), .bReady(1'b0), .rValid(1'b0), .rReady(1'b0),
    .lsuReq(lsuBus.req), .lsuGnt(lsuBus.gnt), .hostReq(hostBus.req), .hostGnt(hostBus.gnt)
);

`default_nettype wire

//--- dv/lsuTb.sv
`timescale 1ns/1ps
`default_nettype none

module lsuTb;
    import lsuPkg::*;

    localparam int MemWords = 256;
    localparam int IdxBits  = $clog2(MemWords);
    localparam int Timeout  = 1000;    // Cycles, longer than the init sweep

    localparam int WaitReqReady  = 0;
    localparam int WaitRespValid = 1;
    localparam int WaitAwReady   = 2;
    localparam int WaitBValid    = 3;
    localparam int WaitArReady   = 4;
    localparam int WaitRValid    = 5;

    logic       clk, reset;
    logic       reqValid, reqReady, reqStore;
    logic [2:0] reqOp;
    word_t      reqAddr, reqData;
    instTag_t   reqTag;
    logic       respValid, respFault;
    instTag_t   respTag;
    word_t      respData;
    logic       awValid, awReady, wValid, wReady, bValid, bReady;
    word_t      awAddr, wData;
    byteEn_t    wStrb;
    logic [1:0] bResp;
    logic       arValid, arReady, rValid, rReady;
    word_t      arAddr, rData;
    logic [1:0] rResp;

    word_t model [MemWords];    // Reference image of the memory
    int    seed = 50733;
    int    errors = 0;
    int    checks = 0;
    int    tests = 0;
    int    testErrors = 0;
    string testName = "";

    lsuTop #(.MemWords(MemWords)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic outOfRange(input word_t addr);
        return addr >= word_t'(MemWords * 4);
    endfunction

    function automatic word_t farAddr();
        return word_t'(MemWords * 4) + (word_t'($random(seed)) & 32'h00ff_fffc);
    endfunction

    // Loads pick from five codes, stores from three
    function automatic logic [2:0] legalOp(input logic store);
        int k;
        k = randBelow(store ? 3 : 5);
        return (k < 3) ? 3'(k) : 3'(k + 1);
    endfunction

    function automatic word_t alignedAddr(input logic [2:0] op, input int idx);
        int lane;
        case (op)
            opByte, opByteU: lane = randBelow(4);
            opHalf, opHalfU: lane = 2 * randBelow(2);
            default:         lane = 0;
        endcase
        return word_t'(idx * 4 + lane);
    endfunction

    function automatic logic expectedFault(input logic store, input logic [2:0] op,
                                           input word_t addr);
        logic bad;
        case (op)
            opByte, opByteU: bad = 1'b0;
            opHalf, opHalfU: bad = addr[0];
            opWord:          bad = addr[1:0] != 2'b00;
            default:         bad = 1'b1;
        endcase
        if (store && op > 3'd2) begin
            bad = 1'b1;
        end
        return bad || outOfRange(addr);
    endfunction

    function automatic word_t loadResult(input logic [2:0] op, input word_t addr);
        word_t w;
        w = model[addr[IdxBits+1:2]] >> (8 * addr[1:0]);
        case (op)
            opByte:  return {{24{w[7]}}, w[7:0]};
            opHalf:  return {{16{w[15]}}, w[15:0]};
            opByteU: return {24'd0, w[7:0]};
            opHalfU: return {16'd0, w[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic void writeModel(input word_t addr, input word_t data, input byteEn_t strb);
        logic [IdxBits-1:0] idx;
        idx = addr[IdxBits+1:2];
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                model[idx][8*b +: 8] = data[8*b +: 8];
            end
        end
    endfunction

    task automatic checkWord(input string what, input word_t exp, input word_t act);
        checks++;
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected %h, actual %h", testName, what, exp, act);
            errors++;
        end
    endtask

    task automatic checkTag(input string what, input instTag_t exp, input instTag_t act);
        checks++;
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected %h, actual %h", testName, what, exp, act);
            errors++;
        end
    endtask

    task automatic checkFault(input string what, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected %0b, actual %0b", testName, what, exp, act);
            errors++;
        end
    endtask

    task automatic checkResp(input string what, input logic [1:0] exp, input logic [1:0] act);
        checks++;
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected %0d, actual %0d", testName, what, exp, act);
            errors++;
        end
    endtask

    function automatic logic isHigh(input int which);
        case (which)
            WaitReqReady:  return reqReady;
            WaitRespValid: return respValid;
            WaitAwReady:   return awReady && wReady;    // Address and data taken together
            WaitBValid:    return bValid;
            WaitArReady:   return arReady;
            default:       return rValid;
        endcase
    endfunction

    // Samples on the falling edge, returns there
    task automatic waitFor(input int which, input string what);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!isHigh(which) && n < Timeout);
        if (!isHigh(which)) begin
            $display("Timeout after %0d cycles waiting for %s in test %s", n, what, testName);
            $display("=== FAIL ===");
            $finish;
        end
    endtask

    task automatic pulseReady(input logic readSide);
        repeat (randBelow(4) + 1) @(posedge clk);
        if (readSide) rReady <= 1'b1;
        else bReady <= 1'b1;
        @(posedge clk);
        if (readSide) rReady <= 1'b0;
        else bReady <= 1'b0;
    endtask

    task automatic lsuAccess(input logic store, input logic [2:0] op, input word_t addr,
                             input word_t data);
        instTag_t tag;
        logic     expFault;
        word_t    expData;
        tag      = instTag_t'($random(seed));
        expFault = expectedFault(store, op, addr);
        expData  = (store || expFault) ? '0 : loadResult(op, addr);
        reqValid <= 1'b1;
        reqStore <= store;
        reqOp    <= op;
        reqAddr  <= addr;
        reqData  <= data;
        reqTag   <= tag;
        waitFor(WaitReqReady, "LSU request accept");
        @(posedge clk);
        reqValid <= 1'b0;
        waitFor(WaitRespValid, "LSU response");
        checkTag("respTag", tag, respTag);
        checkFault("respFault", expFault, respFault);
        checkWord("respData", expData, respData);
        if (store && !expFault) begin
            case (op)
                opByte:  writeModel(addr, data << (8 * addr[1:0]), 4'b0001 << addr[1:0]);
                opHalf:  writeModel(addr, data << (8 * addr[1:0]), 4'b0011 << addr[1:0]);
                default: writeModel(addr, data, 4'b1111);
            endcase
        end
        @(posedge clk);
    endtask

    task automatic axiWrite(input word_t addr, input word_t data, input byteEn_t strb);
        logic [1:0] expResp;
        expResp = outOfRange(addr) ? 2'd2 : 2'd0;
        awValid <= 1'b1;
        awAddr  <= addr;
        wValid  <= 1'b1;
        wData   <= data;
        wStrb   <= strb;
        waitFor(WaitAwReady, "AXI write accept");
        @(posedge clk);
        awValid <= 1'b0;
        wValid  <= 1'b0;
        waitFor(WaitBValid, "AXI write response");
        checkResp("bResp", expResp, bResp);
        if (expResp == 2'd0) begin
            writeModel(addr, data, strb);
        end
        pulseReady(1'b0);
    endtask

    task automatic axiRead(input word_t addr);
        logic [1:0] expResp;
        expResp = outOfRange(addr) ? 2'd2 : 2'd0;
        arValid <= 1'b1;
        arAddr  <= addr;
        waitFor(WaitArReady, "AXI read accept");
        @(posedge clk);
        arValid <= 1'b0;
        waitFor(WaitRValid, "AXI read data");
        checkResp("rResp", expResp, rResp);
        if (expResp == 2'd0) begin
            checkWord("rData", model[addr[IdxBits+1:2]], rData);
        end
        pulseReady(1'b1);
    endtask

    task automatic randomLsu(input int base, input int span);
        logic       store;
        logic [2:0] op;
        store = randBelow(2) == 1;
        op    = legalOp(store);
        lsuAccess(store, op, alignedAddr(op, base + randBelow(span)), word_t'($random(seed)));
    endtask

    task automatic randomAxi(input int base, input int span);
        word_t addr;
        addr = word_t'((base + randBelow(span)) * 4);
        if (randBelow(2) == 1) axiWrite(addr, word_t'($random(seed)), byteEn_t'($random(seed)));
        else axiRead(addr);
    endtask

    task automatic faultAccess();
        int         k;
        int         pick;
        logic       store;
        logic [2:0] op;
        word_t      addr;
        k     = randBelow(5);
        store = randBelow(2) == 1;
        addr  = word_t'(randBelow(MemWords) * 4);
        op    = opWord;
        case (k)
            0: begin
                op   = (store || randBelow(2) == 1) ? opHalf : opHalfU;
                addr = addr + word_t'(1 + 2 * randBelow(2));
            end
            1: addr = addr + word_t'(1 + randBelow(3));
            2: begin
                op   = legalOp(store);
                addr = farAddr();
            end
            3: begin
                pick = randBelow(3);
                op   = (pick == 0) ? 3'd3 : 3'(pick + 5);    // Illegal set is 3, 6, 7
            end
            default: begin
                store = 1'b1;
                op    = 3'(4 + randBelow(2));    // Unsigned store codes
            end
        endcase
        lsuAccess(store, op, addr, word_t'($random(seed)));
    endtask

    task automatic axiThenRead();
        int         idx;
        logic [2:0] op;
        idx = randBelow(MemWords);
        axiWrite(word_t'(idx * 4), word_t'($random(seed)), byteEn_t'($random(seed)));
        if (randBelow(2) == 1) begin
            axiRead(word_t'(idx * 4));
        end else begin
            op = legalOp(1'b0);
            lsuAccess(1'b0, op, alignedAddr(op, idx), '0);
        end
    endtask

    task automatic verifyAll();
        for (int i = 0; i < MemWords; i++) begin
            axiRead(word_t'(i * 4));
        end
    endtask

    task automatic startTest(input string name);
        testName   = name;
        testErrors = errors;
    endtask

    task automatic endTest();
        tests++;
        $display("Test %s finished with %0d errors", testName, errors - testErrors);
    endtask

    initial begin
        int assertFails;
        reset    = 1'b1;
        reqValid = 1'b0;
        reqStore = 1'b0;
        reqOp    = 3'd0;
        reqAddr  = '0;
        reqData  = '0;
        reqTag   = '0;
        awValid  = 1'b0;
        awAddr   = '0;
        wValid   = 1'b0;
        wData    = '0;
        wStrb    = '0;
        bReady   = 1'b0;
        arValid  = 1'b0;
        arAddr   = '0;
        rReady   = 1'b0;
        for (int i = 0; i < MemWords; i++) begin
            model[IdxBits'(i)] = word_t'(i) + word_t'(InitOffset);
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        startTest("init");
        repeat (16) axiRead(word_t'(randBelow(MemWords) * 4));
        endTest();

        startTest("loadStore");
        repeat (200) randomLsu(0, MemWords);
        endTest();

        startTest("faults");
        repeat (40) faultAccess();
        repeat (4) begin
            axiWrite(farAddr(), word_t'($random(seed)), 4'hf);
            axiRead(farAddr());
        end
        verifyAll();
        endTest();

        startTest("axiAccess");
        repeat (60) axiThenRead();
        endTest();

        // LSU owns the low half, AXI the high half
        startTest("shared");
        fork
            repeat (120) randomLsu(0, MemWords / 2);
            repeat (80) randomAxi(MemWords / 2, MemWords / 2);
        join
        verifyAll();
        endTest();

        assertFails = dut0.axi0.axiChk0.fails + dut0.arb0.arbChk0.fails;
        if (assertFails != 0) begin
            $display("Protocol assertions failed %0d times", assertFails);
            errors += assertFails;
        end
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- lsuSubsystem.f
common/lsuPkg.sv
common/memBusIf.sv
rtl/loadStoreUnit.sv
rtl/axiLiteSlave.sv
rtl/memArbiter.sv
dataMemory/dataMemory.sv
rtl/lsuTop.sv
dv/lsuChecker.sv
dv/lsuTb.sv

//--- rtl/axiLiteSlave.sv
`timescale 1ns/1ps
`default_nettype none

module axiLiteSlave #(
    parameter int MemWords = 2048
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            awValid,
    output logic            awReady,
    input  lsuPkg::word_t   awAddr,
    input  logic            wValid,
    output logic            wReady,
    input  lsuPkg::word_t   wData,
    input  lsuPkg::byteEn_t wStrb,
    output logic            bValid,
    input  logic            bReady,
    output logic [1:0]      bResp,
    input  logic            arValid,
    output logic            arReady,
    input  lsuPkg::word_t   arAddr,
    output logic            rValid,
    input  logic            rReady,
    output lsuPkg::word_t   rData,
    output logic [1:0]      rResp,
    memBusIf.requester      bus
);
    import lsuPkg::*;

    localparam int         AddrBits   = $clog2(MemWords);
    localparam logic [1:0] RespOkay   = 2'd0;
    localparam logic [1:0] RespSlvErr = 2'd2;

    typedef enum logic [2:0] {
        stIdle, stWrite, stRead, stReadWait, stWriteResp, stReadResp
    } state_e;

    state_e              state;
    logic                warm;       // Memory sweep has finished
    logic [AddrBits-1:0] warmCnt;
    logic                takeWrite;
    logic                takeRead;
    logic                awBad;
    logic                arBad;
    logic [AddrBits-1:0] addrHold;
    word_t               dataHold;
    byteEn_t             strbHold;
    logic [1:0]          respCode;

    // Tracks the memory init sweep, one word per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            warm    <= 1'b0;
            warmCnt <= '0;
        end else if (!warm) begin
            warmCnt <= warmCnt + 1'b1;
            if (warmCnt == '1) begin
                warm <= 1'b1;
            end
        end
    end

    assign awBad     = |awAddr[31:AddrBits+2];
    assign arBad     = |arAddr[31:AddrBits+2];
    assign takeWrite = (state == stIdle) && warm && awValid && wValid;
    assign takeRead  = (state == stIdle) && warm && arValid && !(awValid && wValid);

    assign awReady = takeWrite;
    assign wReady  = takeWrite;
    assign arReady = takeRead;       // Loses to a write in the same cycle
    assign bValid  = (state == stWriteResp);
    assign rValid  = (state == stReadResp);
    assign bResp   = respCode;
    assign rResp   = respCode;

    assign bus.req      = (state == stWrite) || (state == stRead);
    assign bus.we       = (state == stWrite);
    assign bus.wordAddr = addrHold;
    assign bus.wdata    = dataHold;
    assign bus.byteEn   = strbHold;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stIdle;
        end else begin
            case (state)
                stIdle: begin
                    if (takeWrite) begin
                        state <= awBad ? stWriteResp : stWrite;
                    end else if (takeRead) begin
                        state <= arBad ? stReadResp : stRead;
                    end
                end
                stWrite:     if (bus.gnt) state <= stWriteResp;
                stRead:      if (bus.gnt) state <= stReadWait;
                stReadWait:  if (bus.rvalid) state <= stReadResp;
                stWriteResp: if (bReady) state <= stIdle;
                stReadResp:  if (rReady) state <= stIdle;
                default:     state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (takeWrite) begin
            addrHold <= awAddr[AddrBits+1:2];
            dataHold <= wData;
            strbHold <= wStrb;
            respCode <= awBad ? RespSlvErr : RespOkay;
        end else if (takeRead) begin
            addrHold <= arAddr[AddrBits+1:2];
            rData    <= '0;                   // Stays zero on SLVERR
            respCode <= arBad ? RespSlvErr : RespOkay;
        end else if (state == stReadWait && bus.rvalid) begin
            rData <= bus.rdata;
        end
    end

endmodule

`default_nettype wire

//--- rtl/loadStoreUnit.sv
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit #(
    parameter int MemWords = 2048
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             reqValid,
    output logic             reqReady,
    input  lsuPkg::lsuReq_t  req,
    output logic             respValid,
    output lsuPkg::lsuResp_t resp,
    memBusIf.requester       bus
);
    import lsuPkg::*;

    localparam int AddrBits = $clog2(MemWords);

    typedef enum logic [1:0] {stIdle, stAccess, stFormat} state_e;

    state_e     state;
    lsuReq_t    held;        // Request under execution
    logic       badOp;
    logic       misaligned;
    logic       badAddr;
    logic       fault;
    logic [1:0] lane;
    word_t      laneData;
    word_t      loadValue;

    // Checks are made on the incoming request so a fault never reaches the bus
    always_comb begin
        badOp      = 1'b0;
        misaligned = 1'b0;
        case (req.op)
            opByte, opByteU: misaligned = 1'b0;
            opHalf, opHalfU: misaligned = req.addr[0];
            opWord:          misaligned = |req.addr[1:0];
            default:         badOp = 1'b1;        // Codes 3, 6, 7
        endcase
        if (req.isStore && (req.op == opByteU || req.op == opHalfU)) begin
            badOp = 1'b1;                         // No unsigned stores
        end
        badAddr = |req.addr[31:AddrBits+2];       // Beyond MemWords*4
        fault   = badOp | misaligned | badAddr;
    end

    assign reqReady = (state == stIdle);
    assign lane     = held.addr[1:0];

    assign bus.req      = (state == stAccess);
    assign bus.we       = held.isStore;
    assign bus.wordAddr = held.addr[AddrBits+1:2];
    assign bus.wdata    = held.storeData << {lane, 3'b000};

    always_comb begin
        case (held.op)
            opByte:  bus.byteEn = 4'b0001 << lane;
            opHalf:  bus.byteEn = 4'b0011 << lane;
            default: bus.byteEn = 4'b1111;
        endcase
    end

    // Selected lane moved down to bit 0
    assign laneData = bus.rdata >> {lane, 3'b000};

    always_comb begin
        case (held.op)
            opByte:  loadValue = {{24{laneData[7]}}, laneData[7:0]};
            opHalf:  loadValue = {{16{laneData[15]}}, laneData[15:0]};
            opByteU: loadValue = {24'b0, laneData[7:0]};
            opHalfU: loadValue = {16'b0, laneData[15:0]};
            default: loadValue = laneData;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= stIdle;
            respValid <= 1'b0;
        end else begin
            respValid <= 1'b0;                    // Single-cycle pulse
            case (state)
                stIdle: begin
                    if (reqValid) begin
                        if (fault) begin
                            respValid <= 1'b1;
                        end else begin
                            state <= stAccess;
                        end
                    end
                end
                stAccess: begin
                    if (bus.gnt) begin
                        if (held.isStore) begin
                            respValid <= 1'b1;
                            state     <= stIdle;
                        end else begin
                            state <= stFormat;
                        end
                    end
                end
                stFormat: begin
                    if (bus.rvalid) begin
                        respValid <= 1'b1;
                        state     <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reqReady && reqValid) begin
            held          <= req;
            resp.tag      <= req.tag;
            resp.loadData <= '0;
            resp.fault    <= fault;
        end else if (state == stFormat && bus.rvalid) begin
            resp.loadData <= loadValue;
        end
    end

endmodule

`default_nettype wire

//--- rtl/lsuTop.sv
`timescale 1ns/1ps
`default_nettype none

module lsuTop #(
    parameter int MemWords = 2048
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             reqValid,
    output logic             reqReady,
    input  logic             reqStore,
    input  logic [2:0]       reqOp,
    input  lsuPkg::word_t    reqAddr,
    input  lsuPkg::word_t    reqData,
    input  lsuPkg::instTag_t reqTag,
    output logic             respValid,
    output lsuPkg::instTag_t respTag,
    output lsuPkg::word_t    respData,
    output logic             respFault,
    input  logic             awValid,
    output logic             awReady,
    input  lsuPkg::word_t    awAddr,
    input  logic             wValid,
    output logic             wReady,
    input  lsuPkg::word_t    wData,
    input  lsuPkg::byteEn_t  wStrb,
    output logic             bValid,
    input  logic             bReady,
    output logic [1:0]       bResp,
    input  logic             arValid,
    output logic             arReady,
    input  lsuPkg::word_t    arAddr,
    output logic             rValid,
    input  logic             rReady,
    output lsuPkg::word_t    rData,
    output logic [1:0]       rResp
);
    import lsuPkg::*;

    localparam int AddrBits = $clog2(MemWords);

    lsuReq_t  lsuReq;
    lsuResp_t lsuResp;

    assign lsuReq.isStore   = reqStore;
    assign lsuReq.op        = memOp_e'(reqOp);    // Illegal codes pass through to the fault check
    assign lsuReq.addr      = reqAddr;
    assign lsuReq.storeData = reqData;
    assign lsuReq.tag       = reqTag;

    assign respTag   = lsuResp.tag;
    assign respData  = lsuResp.loadData;
    assign respFault = lsuResp.fault;

    memBusIf #(.AddrBits(AddrBits)) lsuBus ();
    memBusIf #(.AddrBits(AddrBits)) hostBus ();
    memBusIf #(.AddrBits(AddrBits)) memBus ();

    loadStoreUnit #(.MemWords(MemWords)) lsu0 (
        .clk, .reset, .reqValid, .reqReady,
        .req(lsuReq), .respValid, .resp(lsuResp), .bus(lsuBus.requester)
    );

    axiLiteSlave #(.MemWords(MemWords)) axi0 (
        .clk, .reset,
        .awValid, .awReady, .awAddr, .wValid, .wReady, .wData, .wStrb,
        .bValid, .bReady, .bResp, .arValid, .arReady, .arAddr,
        .rValid, .rReady, .rData, .rResp, .bus(hostBus.requester)
    );

    memArbiter arb0 (
        .clk, .reset,
        .lsuBus(lsuBus.arbiter), .hostBus(hostBus.arbiter), .memBus(memBus.requester)
    );

    dataMemory #(.MemWords(MemWords)) mem0 (
        .clk, .reset, .bus(memBus.memory)
    );

endmodule

`default_nettype wire

//--- rtl/memArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
    input  logic       clk,
    input  logic       reset,
    memBusIf.arbiter   lsuBus,
    memBusIf.arbiter   hostBus,
    memBusIf.requester memBus
);
    logic pickHost;    // Host side wins this cycle
    logic lastHost;    // Winner of the most recent grant
    logic granted;

    // Round robin only matters when both sides ask
    always_comb begin
        if (lsuBus.req && hostBus.req) begin
            pickHost = !lastHost;
        end else begin
            pickHost = hostBus.req;
        end
    end

    assign memBus.req      = lsuBus.req | hostBus.req;
    assign memBus.we       = pickHost ? hostBus.we       : lsuBus.we;
    assign memBus.wordAddr = pickHost ? hostBus.wordAddr : lsuBus.wordAddr;
    assign memBus.wdata    = pickHost ? hostBus.wdata    : lsuBus.wdata;
    assign memBus.byteEn   = pickHost ? hostBus.byteEn   : lsuBus.byteEn;

    assign granted     = memBus.req & memBus.gnt;
    assign lsuBus.gnt  = granted & ~pickHost;
    assign hostBus.gnt = granted & pickHost;

    // Also steers the read data returning one cycle after the grant
    always_ff @(posedge clk) begin
        if (reset) begin
            lastHost <= 1'b0;
        end else if (granted) begin
            lastHost <= pickHost;
        end
    end

    assign lsuBus.rvalid  = memBus.rvalid & ~lastHost;
    assign hostBus.rvalid = memBus.rvalid & lastHost;
    assign lsuBus.rdata   = memBus.rdata;
    assign hostBus.rdata  = memBus.rdata;

endmodule

`default_nettype wire
